//--- design/valu_cfg.svh
`ifndef VALU_CFG_SVH
`define VALU_CFG_SVH

// Datapath word and its byte enables
`define VALU_ELEN 64
`define VALU_STRB 8

// Vector register geometry
`define VALU_VLEN 512
`define VALU_VREG_WORDS (`VALU_VLEN / `VALU_ELEN)
// Vector length, up to 64 elements
`define VALU_VL_W 7
`define VALU_ADDR_W 8

// Instruction ids
`define VALU_NR_VINSN 8
`define VALU_ID_W 3

// Queue depths
`define VALU_INSN_DEPTH 4
`define VALU_RESULT_DEPTH 2

`endif

//--- design/valu_pkg.sv
package valu_pkg;

  ////////////////////
  // Operations
  ////////////////////

  // Integer operations of the vector ALU
  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VRSUB,
    VAND,
    VOR,
    VXOR,
    VMINU,
    VMIN,
    VMAXU,
    VMAX
  } alu_op_e;

  // Element width, log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

endpackage

//--- design/valu_simd_alu.sv
`timescale 1ns/10ps
`include "valu_cfg.svh"

module valu_simd_alu (
  input  logic [`VALU_ELEN-1:0] operand_a_i,
  input  logic [`VALU_ELEN-1:0] operand_b_i,
  input  valu_pkg::alu_op_e     op_i,
  input  valu_pkg::vew_e        vew_i,
  output logic [`VALU_ELEN-1:0] result_o
);

  // One element, zero extended to 64 bits on entry
  // Shift amount sh sign-extends it again for the signed compares
  function automatic logic [63:0] elem_op(valu_pkg::alu_op_e op, logic [63:0] a,
                                          logic [63:0] b, int unsigned sh);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        r;
    sa = $signed(a << sh) >>> sh;
    sb = $signed(b << sh) >>> sh;
    unique case (op)
      // Upper bits are dropped by the caller, so the sum wraps
      valu_pkg::VADD:  r = a + b;
      valu_pkg::VSUB:  r = a - b;
      valu_pkg::VRSUB: r = b - a;
      valu_pkg::VAND:  r = a & b;
      valu_pkg::VOR:   r = a | b;
      valu_pkg::VXOR:  r = a ^ b;
      valu_pkg::VMINU: r = (a < b) ? a : b;
      valu_pkg::VMIN:  r = (sa < sb) ? a : b;
      valu_pkg::VMAXU: r = (a > b) ? a : b;
      valu_pkg::VMAX:  r = (sa > sb) ? a : b;
      default:         r = '0;
    endcase
    return r;
  endfunction

  ////////////////////
  // SIMD lanes
  ////////////////////

  always_comb begin
    logic [63:0] elem;
    result_o = '0;
    elem     = '0;
    unique case (vew_i)
      // Eight bytes per word
      valu_pkg::EW8: begin
        for (int e = 0; e < 8; e++) begin
          elem = elem_op(op_i, 64'(operand_a_i[8*e +: 8]), 64'(operand_b_i[8*e +: 8]), 56);
          result_o[8*e +: 8] = elem[7:0];
        end
      end
      // Four halfwords
      valu_pkg::EW16: begin
        for (int e = 0; e < 4; e++) begin
          elem = elem_op(op_i, 64'(operand_a_i[16*e +: 16]), 64'(operand_b_i[16*e +: 16]), 48);
          result_o[16*e +: 16] = elem[15:0];
        end
      end
      // Two words
      valu_pkg::EW32: begin
        for (int e = 0; e < 2; e++) begin
          elem = elem_op(op_i, 64'(operand_a_i[32*e +: 32]), 64'(operand_b_i[32*e +: 32]), 32);
          result_o[32*e +: 32] = elem[31:0];
        end
      end
      // Full 64-bit element
      default: begin
        elem     = elem_op(op_i, operand_a_i, operand_b_i, 0);
        result_o = elem;
      end
    endcase
  end

endmodule

//--- design/valu_issue.sv
`timescale 1ns/10ps
`include "valu_cfg.svh"

module valu_issue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Instruction input
  input  valu_pkg::alu_op_e             insn_op_i,
  input  valu_pkg::vew_e                insn_vew_i,
  input  logic [`VALU_VL_W-1:0]         insn_vl_i,
  input  logic [4:0]                    insn_vd_i,
  input  logic [`VALU_ID_W-1:0]         insn_id_i,
  input  logic                          insn_use_scalar_i,
  input  logic [`VALU_ELEN-1:0]         insn_scalar_i,
  input  logic                          insn_valid_i,
  output logic                          insn_ready_o,
  // Operand queues
  input  logic [1:0][`VALU_ELEN-1:0]    operand_i,
  input  logic [1:0]                    operand_valid_i,
  output logic [1:0]                    operand_ready_o,
  // Result queue write side
  input  logic                          rq_full_i,
  output logic                          rq_push_o,
  output logic [`VALU_ELEN-1:0]         rq_wdata_o,
  output logic [`VALU_ADDR_W-1:0]       rq_addr_o,
  output logic [`VALU_STRB-1:0]         rq_be_o,
  output logic [`VALU_ID_W-1:0]         rq_id_o,
  output logic                          rq_last_o,
  // Commit stage
  input  logic                          insn_commit_i
);

  localparam int unsigned pnt_w = $clog2(`VALU_INSN_DEPTH);
  localparam int unsigned cnt_w = $clog2(`VALU_INSN_DEPTH) + 1;

  ////////////////////
  // Instruction queue
  ////////////////////

  valu_pkg::alu_op_e      op_q         [`VALU_INSN_DEPTH];
  valu_pkg::vew_e         vew_q        [`VALU_INSN_DEPTH];
  logic [`VALU_VL_W-1:0]  vl_q         [`VALU_INSN_DEPTH];
  logic [4:0]             vd_q         [`VALU_INSN_DEPTH];
  logic [`VALU_ID_W-1:0]  id_q         [`VALU_INSN_DEPTH];
  logic                   use_scalar_q [`VALU_INSN_DEPTH];
  logic [`VALU_ELEN-1:0]  scalar_q     [`VALU_INSN_DEPTH];

  // Accept and issue pointers
  logic [pnt_w-1:0] accept_pnt_q;
  logic [pnt_w-1:0] issue_pnt_q;
  // Waiting to issue, and in flight until commit
  logic [cnt_w-1:0] issue_cnt_q;
  logic [cnt_w-1:0] commit_cnt_q;

  logic accept;

  // Full once every slot waits for its done
  assign insn_ready_o = (commit_cnt_q != cnt_w'(`VALU_INSN_DEPTH));
  assign accept       = insn_valid_i && insn_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]         <= insn_op_i;
      vew_q[accept_pnt_q]        <= insn_vew_i;
      vl_q[accept_pnt_q]         <= insn_vl_i;
      vd_q[accept_pnt_q]         <= insn_vd_i;
      id_q[accept_pnt_q]         <= insn_id_i;
      use_scalar_q[accept_pnt_q] <= insn_use_scalar_i;
      scalar_q[accept_pnt_q]     <= insn_scalar_i;
    end
  end

  // Instruction at the issue pointer
  valu_pkg::alu_op_e     cur_op;
  valu_pkg::vew_e        cur_vew;
  logic [`VALU_VL_W-1:0] cur_vl;
  logic                  cur_use_scalar;
  logic [`VALU_ELEN-1:0] cur_scalar;

  assign cur_op         = op_q[issue_pnt_q];
  assign cur_vew        = vew_q[issue_pnt_q];
  assign cur_vl         = vl_q[issue_pnt_q];
  assign cur_use_scalar = use_scalar_q[issue_pnt_q];
  assign cur_scalar     = scalar_q[issue_pnt_q];

  ////////////////////
  // Element bookkeeping
  ////////////////////

  logic [1:0]            ew;
  logic [1:0]            shift;
  logic [3:0]            elems_per_word;
  logic [`VALU_VL_W-1:0] elem_done_q;
  logic [`VALU_VL_W-1:0] elems_left;
  logic [`VALU_VL_W-1:0] elem_cnt;
  logic [`VALU_VL_W-1:0] word_idx;
  logic [3:0]            byte_cnt;
  logic                  word_last;

  // 8, 4, 2 or 1 elements per word
  assign ew             = cur_vew;
  assign shift          = 2'd3 - ew;
  assign elems_per_word = 4'd1 << shift;
  assign elems_left     = cur_vl - elem_done_q;

  // Partial last word takes only what remains
  assign word_last = (elems_left <= `VALU_VL_W'(elems_per_word));
  assign elem_cnt  = word_last ? elems_left : `VALU_VL_W'(elems_per_word);
  assign byte_cnt  = 4'(elem_cnt[3:0] << ew);
  assign word_idx  = elem_done_q >> shift;

  ////////////////////
  // Operands
  ////////////////////

  logic [`VALU_ELEN-1:0] scalar_rep;
  logic [`VALU_ELEN-1:0] operand_a;

  // Scalar copied into every element of the word
  always_comb begin
    unique case (cur_vew)
      valu_pkg::EW8:  scalar_rep = {8{cur_scalar[7:0]}};
      valu_pkg::EW16: scalar_rep = {4{cur_scalar[15:0]}};
      valu_pkg::EW32: scalar_rep = {2{cur_scalar[31:0]}};
      default:        scalar_rep = cur_scalar;
    endcase
  end

  assign operand_a = cur_use_scalar ? scalar_rep : operand_i[0];

  valu_simd_alu i_simd_alu (
    .operand_a_i (operand_a),
    .operand_b_i (operand_i[1]),
    .op_i        (cur_op),
    .vew_i       (cur_vew),
    .result_o    (rq_wdata_o)
  );

  ////////////////////
  // Issue
  ////////////////////

  logic issue_valid;
  logic operands_ok;
  logic issue_fire;

  assign issue_valid = (issue_cnt_q != '0);
  // Slot 0 not needed with a scalar first operand
  assign operands_ok = operand_valid_i[1] && (operand_valid_i[0] || cur_use_scalar);
  assign issue_fire  = issue_valid && operands_ok && !rq_full_i;

  // Acknowledge and push in the same cycle
  assign operand_ready_o = {issue_fire, issue_fire && !cur_use_scalar};
  assign rq_push_o       = issue_fire;
  assign rq_addr_o       = `VALU_ADDR_W'(vd_q[issue_pnt_q] * `VALU_VREG_WORDS) +
                           `VALU_ADDR_W'(word_idx);
  assign rq_be_o         = {`VALU_STRB{1'b1}} >> (`VALU_STRB - byte_cnt);
  assign rq_id_o         = id_q[issue_pnt_q];
  assign rq_last_o       = word_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      elem_done_q  <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_fire) begin
        // Last word moves on to the next instruction
        if (word_last) begin
          issue_pnt_q <= issue_pnt_q + 1'b1;
          elem_done_q <= '0;
        end else begin
          elem_done_q <= elem_done_q + `VALU_VL_W'(elems_per_word);
        end
      end
      issue_cnt_q  <= issue_cnt_q + cnt_w'(accept) - cnt_w'(issue_fire && word_last);
      commit_cnt_q <= commit_cnt_q + cnt_w'(accept) - cnt_w'(insn_commit_i);
    end
  end

endmodule

//--- design/valu_result_queue.sv
`timescale 1ns/10ps
`include "valu_cfg.svh"

module valu_result_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Write side
  input  logic                    push_i,
  input  logic [`VALU_ELEN-1:0]   wdata_i,
  input  logic [`VALU_ADDR_W-1:0] addr_i,
  input  logic [`VALU_STRB-1:0]   be_i,
  input  logic [`VALU_ID_W-1:0]   id_i,
  input  logic                    last_i,
  output logic                    full_o,
  // Head of the queue
  output logic                    valid_o,
  output logic [`VALU_ELEN-1:0]   wdata_o,
  output logic [`VALU_ADDR_W-1:0] addr_o,
  output logic [`VALU_STRB-1:0]   be_o,
  output logic [`VALU_ID_W-1:0]   id_o,
  output logic                    last_o,
  input  logic                    pop_i
);

  localparam int unsigned pnt_w = $clog2(`VALU_RESULT_DEPTH);
  localparam int unsigned cnt_w = $clog2(`VALU_RESULT_DEPTH) + 1;

  // Word payload per entry
  logic [`VALU_ELEN-1:0]   wdata_q [`VALU_RESULT_DEPTH];
  logic [`VALU_ADDR_W-1:0] addr_q  [`VALU_RESULT_DEPTH];
  logic [`VALU_STRB-1:0]   be_q    [`VALU_RESULT_DEPTH];
  logic [`VALU_ID_W-1:0]   id_q    [`VALU_RESULT_DEPTH];
  logic                    last_q  [`VALU_RESULT_DEPTH];

  logic [pnt_w-1:0] write_pnt_q;
  logic [pnt_w-1:0] read_pnt_q;
  logic [cnt_w-1:0] cnt_q;

  assign full_o  = (cnt_q == cnt_w'(`VALU_RESULT_DEPTH));
  assign valid_o = (cnt_q != '0);

  assign wdata_o = wdata_q[read_pnt_q];
  assign addr_o  = addr_q[read_pnt_q];
  assign be_o    = be_q[read_pnt_q];
  assign id_o    = id_q[read_pnt_q];
  assign last_o  = last_q[read_pnt_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      wdata_q[write_pnt_q] <= wdata_i;
      addr_q[write_pnt_q]  <= addr_i;
      be_q[write_pnt_q]    <= be_i;
      id_q[write_pnt_q]    <= id_i;
      last_q[write_pnt_q]  <= last_i;
    end
  end

  // Push and pop may coincide
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_pnt_q <= '0;
      read_pnt_q  <= '0;
      cnt_q       <= '0;
    end else begin
      if (push_i) begin
        write_pnt_q <= write_pnt_q + 1'b1;
      end
      if (pop_i) begin
        read_pnt_q <= read_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + cnt_w'(push_i) - cnt_w'(pop_i);
    end
  end

endmodule

//--- design/valu_commit.sv
`timescale 1ns/10ps
`include "valu_cfg.svh"

module valu_commit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Result queue head
  input  logic                      rq_valid_i,
  input  logic [`VALU_ELEN-1:0]     rq_wdata_i,
  input  logic [`VALU_ADDR_W-1:0]   rq_addr_i,
  input  logic [`VALU_STRB-1:0]     rq_be_i,
  input  logic [`VALU_ID_W-1:0]     rq_id_i,
  input  logic                      rq_last_i,
  output logic                      rq_pop_o,
  // Register file write port
  output logic                      result_req_o,
  output logic [`VALU_ID_W-1:0]     result_id_o,
  output logic [`VALU_ADDR_W-1:0]   result_addr_o,
  output logic [`VALU_ELEN-1:0]     result_wdata_o,
  output logic [`VALU_STRB-1:0]     result_be_o,
  input  logic                      result_gnt_i,
  // Completion
  output logic [`VALU_NR_VINSN-1:0] vinsn_done_o,
  output logic                      insn_commit_o
);

  logic req_q;
  logic last_q;
  logic granted;
  logic load;

  // Refill when empty or when the held word leaves this cycle
  assign granted  = req_q && result_gnt_i;
  assign load     = rq_valid_i && (!req_q || result_gnt_i);
  assign rq_pop_o = load;

  assign result_req_o = req_q;

  // Output word held stable until granted
  always_ff @(posedge clk_i) begin
    if (load) begin
      result_id_o    <= rq_id_i;
      result_addr_o  <= rq_addr_i;
      result_wdata_o <= rq_wdata_i;
      result_be_o    <= rq_be_i;
      last_q         <= rq_last_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q         <= 1'b0;
      vinsn_done_o  <= '0;
      insn_commit_o <= 1'b0;
    end else begin
      if (load) begin
        req_q <= 1'b1;
      end else if (granted) begin
        req_q <= 1'b0;
      end
      // One-cycle done for the id of a granted last word
      vinsn_done_o  <= (granted && last_q) ? `VALU_NR_VINSN'(1) << result_id_o : '0;
      insn_commit_o <= granted && last_q;
    end
  end

endmodule

//--- design/valu.sv
`timescale 1ns/10ps
`include "valu_cfg.svh"

module valu (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Instructions
  input  valu_pkg::alu_op_e             insn_op_i,
  input  valu_pkg::vew_e                insn_vew_i,
  input  logic [`VALU_VL_W-1:0]         insn_vl_i,
  input  logic [4:0]                    insn_vd_i,
  input  logic [`VALU_ID_W-1:0]         insn_id_i,
  input  logic                          insn_use_scalar_i,
  input  logic [`VALU_ELEN-1:0]         insn_scalar_i,
  input  logic                          insn_valid_i,
  output logic                          insn_ready_o,
  // Operands
  input  logic [1:0][`VALU_ELEN-1:0]    operand_i,
  input  logic [1:0]                    operand_valid_i,
  output logic [1:0]                    operand_ready_o,
  // Register file write port
  output logic                          result_req_o,
  output logic [`VALU_ID_W-1:0]         result_id_o,
  output logic [`VALU_ADDR_W-1:0]       result_addr_o,
  output logic [`VALU_ELEN-1:0]         result_wdata_o,
  output logic [`VALU_STRB-1:0]         result_be_o,
  input  logic                          result_gnt_i,
  output logic [`VALU_NR_VINSN-1:0]     vinsn_done_o
);

  ////////////////////
  // Internal wires
  ////////////////////

  // Issue to result queue
  logic                    rq_push;
  logic [`VALU_ELEN-1:0]   rq_wdata;
  logic [`VALU_ADDR_W-1:0] rq_addr;
  logic [`VALU_STRB-1:0]   rq_be;
  logic [`VALU_ID_W-1:0]   rq_id;
  logic                    rq_last;
  logic                    rq_full;
  // Result queue head to commit
  logic                    rq_valid;
  logic                    rq_pop;
  logic [`VALU_ELEN-1:0]   rq_head_wdata;
  logic [`VALU_ADDR_W-1:0] rq_head_addr;
  logic [`VALU_STRB-1:0]   rq_head_be;
  logic [`VALU_ID_W-1:0]   rq_head_id;
  logic                    rq_head_last;
  // Frees one in-flight slot
  logic                    insn_commit;

  valu_issue i_issue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .insn_op_i         (insn_op_i),
    .insn_vew_i        (insn_vew_i),
    .insn_vl_i         (insn_vl_i),
    .insn_vd_i         (insn_vd_i),
    .insn_id_i         (insn_id_i),
    .insn_use_scalar_i (insn_use_scalar_i),
    .insn_scalar_i     (insn_scalar_i),
    .insn_valid_i      (insn_valid_i),
    .insn_ready_o      (insn_ready_o),
    .operand_i         (operand_i),
    .operand_valid_i   (operand_valid_i),
    .operand_ready_o   (operand_ready_o),
    .rq_full_i         (rq_full),
    .rq_push_o         (rq_push),
    .rq_wdata_o        (rq_wdata),
    .rq_addr_o         (rq_addr),
    .rq_be_o           (rq_be),
    .rq_id_o           (rq_id),
    .rq_last_o         (rq_last),
    .insn_commit_i     (insn_commit)
  );

  valu_result_queue i_result_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rq_push),
    .wdata_i (rq_wdata),
    .addr_i  (rq_addr),
    .be_i    (rq_be),
    .id_i    (rq_id),
    .last_i  (rq_last),
    .full_o  (rq_full),
    .valid_o (rq_valid),
    .wdata_o (rq_head_wdata),
    .addr_o  (rq_head_addr),
    .be_o    (rq_head_be),
    .id_o    (rq_head_id),
    .last_o  (rq_head_last),
    .pop_i   (rq_pop)
  );

  valu_commit i_commit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rq_valid_i     (rq_valid),
    .rq_wdata_i     (rq_head_wdata),
    .rq_addr_i      (rq_head_addr),
    .rq_be_i        (rq_head_be),
    .rq_id_i        (rq_head_id),
    .rq_last_i      (rq_head_last),
    .rq_pop_o       (rq_pop),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .vinsn_done_o   (vinsn_done_o),
    .insn_commit_o  (insn_commit)
  );

endmodule

//--- sim/tb_valu.sv
`timescale 1ns/10ps
`include "valu_cfg.svh"

module tb_valu;

  localparam int unsigned num_insn   = 60;
  // Up to 8 words per instruction, a few cycles each under back-pressure
  localparam int unsigned max_cycles = num_insn * `VALU_VREG_WORDS * 8;

  typedef struct packed {
    valu_pkg::alu_op_e     op;
    valu_pkg::vew_e        vew;
    logic [`VALU_VL_W-1:0] vl;
    logic [4:0]            vd;
    logic [`VALU_ID_W-1:0] id;
    logic                  use_scalar;
    logic [`VALU_ELEN-1:0] scalar;
  } insn_t;

  // One expected register file write
  typedef struct packed {
    logic [`VALU_ID_W-1:0]   id;
    logic [`VALU_ADDR_W-1:0] addr;
    logic [`VALU_ELEN-1:0]   data;
    logic [`VALU_STRB-1:0]   be;
    logic                    last;
  } word_t;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  valu_pkg::alu_op_e             insn_op_i;
  valu_pkg::vew_e                insn_vew_i;
  logic [`VALU_VL_W-1:0]         insn_vl_i;
  logic [4:0]                    insn_vd_i;
  logic [`VALU_ID_W-1:0]         insn_id_i;
  logic                          insn_use_scalar_i;
  logic [`VALU_ELEN-1:0]         insn_scalar_i;
  logic                          insn_valid_i;
  logic                          insn_ready_o;
  logic [1:0][`VALU_ELEN-1:0]    operand_i;
  logic [1:0]                    operand_valid_i;
  logic [1:0]                    operand_ready_o;
  logic                          result_req_o;
  logic [`VALU_ID_W-1:0]         result_id_o;
  logic [`VALU_ADDR_W-1:0]       result_addr_o;
  logic [`VALU_ELEN-1:0]         result_wdata_o;
  logic [`VALU_STRB-1:0]         result_be_o;
  logic                          result_gnt_i;
  logic [`VALU_NR_VINSN-1:0]     vinsn_done_o;

  // Scoreboard and bookkeeping
  insn_t                     insn_q[$];
  word_t                     exp_q[$];
  int                        elem_pos      = 0;
  int                        inflight      = 0;
  int unsigned               done_cnt      = 0;
  int unsigned               sent_cnt      = 0;
  int unsigned               cycle_cnt     = 0;
  int                        gnt_hold      = 0;
  logic [`VALU_NR_VINSN-1:0] done_exp      = '0;
  logic                      insn_taken    = 1'b0;
  logic [1:0]                opnd_taken    = 2'b00;
  logic                      ready_dropped = 1'b0;
  logic [31:0]               lfsr          = 32'hf8715b1a;

  valu valu_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .insn_op_i         (insn_op_i),
    .insn_vew_i        (insn_vew_i),
    .insn_vl_i         (insn_vl_i),
    .insn_vd_i         (insn_vd_i),
    .insn_id_i         (insn_id_i),
    .insn_use_scalar_i (insn_use_scalar_i),
    .insn_scalar_i     (insn_scalar_i),
    .insn_valid_i      (insn_valid_i),
    .insn_ready_o      (insn_ready_o),
    .operand_i         (operand_i),
    .operand_valid_i   (operand_valid_i),
    .operand_ready_o   (operand_ready_o),
    .result_req_o      (result_req_o),
    .result_id_o       (result_id_o),
    .result_addr_o     (result_addr_o),
    .result_wdata_o    (result_wdata_o),
    .result_be_o       (result_be_o),
    .result_gnt_i      (result_gnt_i),
    .vinsn_done_o      (vinsn_done_o)
  );

  always #50 clk_i = ~clk_i;

  ////////////////////
  // Helpers
  ////////////////////

  task automatic abort_run(input string reason);
    $display("Testbench failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      abort_run("Output value mismatch");
    end
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      v    = {v[62:0], lfsr[31]};
      lfsr = {lfsr[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [63:0] elem_mask(input int unsigned w);
    return (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
  endfunction

  // Bytes outside the enables are don't care
  function automatic logic [63:0] byte_mask(input logic [7:0] be);
    logic [63:0] m;
    m = '0;
    for (int i = 0; i < 8; i++) begin
      if (be[i]) m[8*i +: 8] = 8'hff;
    end
    return m;
  endfunction

  function automatic logic [63:0] replicate(input logic [63:0] s, input valu_pkg::vew_e vew);
    int unsigned w;
    logic [63:0] res;
    w   = 8 << vew;
    res = '0;
    for (int unsigned i = 0; i < 64 / w; i++) begin
      res = res | ((s & elem_mask(w)) << (i * w));
    end
    return res;
  endfunction

  // Expected word, element by element
  function automatic logic [63:0] ref_alu(input valu_pkg::alu_op_e op, input valu_pkg::vew_e vew,
                                          input logic [63:0] a, input logic [63:0] b);
    int unsigned w;
    logic [63:0] mask;
    logic [63:0] sign;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] r;
    logic [63:0] res;
    w    = 8 << vew;
    mask = elem_mask(w);
    sign = 64'd1 << (w - 1);
    res  = '0;
    for (int unsigned i = 0; i < 64 / w; i++) begin
      ea = (a >> (i * w)) & mask;
      eb = (b >> (i * w)) & mask;
      case (op)
        valu_pkg::VADD:  r = ea + eb;
        valu_pkg::VSUB:  r = ea - eb;
        valu_pkg::VRSUB: r = eb - ea;
        valu_pkg::VAND:  r = ea & eb;
        valu_pkg::VOR:   r = ea | eb;
        valu_pkg::VXOR:  r = ea ^ eb;
        valu_pkg::VMINU: r = (ea < eb) ? ea : eb;
        valu_pkg::VMAXU: r = (ea > eb) ? ea : eb;
        // Flipping the sign bit turns a signed compare into an unsigned one
        valu_pkg::VMIN:  r = ((ea ^ sign) < (eb ^ sign)) ? ea : eb;
        valu_pkg::VMAX:  r = ((ea ^ sign) > (eb ^ sign)) ? ea : eb;
        default:         r = '0;
      endcase
      res = res | ((r & mask) << (i * w));
    end
    return res;
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic drive_insn();
    if (!insn_valid_i || insn_taken) begin
      if (sent_cnt < num_insn && rand_bits(2) != '0) begin
        insn_op_i         = valu_pkg::alu_op_e'(4'(rand_bits(4) % 64'd10));
        insn_vew_i        = valu_pkg::vew_e'(2'(rand_bits(2)));
        // At most one register worth of elements
        insn_vl_i         = 7'(64'd1 + rand_bits(6) % (64'd64 >> insn_vew_i));
        insn_vd_i         = 5'(rand_bits(5));
        insn_id_i         = 3'(sent_cnt);
        insn_use_scalar_i = 1'(rand_bits(1));
        insn_scalar_i     = rand_bits(64);
        insn_valid_i      = 1'b1;
        sent_cnt++;
      end else begin
        insn_valid_i = 1'b0;
      end
    end
  endtask

  // Each slot holds its word until taken, with random gaps
  task automatic drive_operands();
    for (int k = 0; k < 2; k++) begin
      if (!operand_valid_i[k] || opnd_taken[k]) begin
        if (rand_bits(2) != '0) begin
          operand_i[k]       = rand_bits(64);
          operand_valid_i[k] = 1'b1;
        end else begin
          operand_valid_i[k] = 1'b0;
        end
      end
    end
  endtask

  // Short random grants, sometimes a long stall
  task automatic drive_gnt();
    if (gnt_hold == 0) begin
      if (rand_bits(3) == '0) begin
        result_gnt_i = 1'b0;
        gnt_hold     = 16 + int'(rand_bits(4));
      end else begin
        result_gnt_i = (rand_bits(2) != '0);
        gnt_hold     = int'(rand_bits(2));
      end
    end else begin
      gnt_hold--;
    end
  endtask

  initial begin
    rst_ni            = 1'b0;
    insn_op_i         = valu_pkg::VADD;
    insn_vew_i        = valu_pkg::EW8;
    insn_vl_i         = '0;
    insn_vd_i         = '0;
    insn_id_i         = '0;
    insn_use_scalar_i = 1'b0;
    insn_scalar_i     = '0;
    insn_valid_i      = 1'b0;
    operand_i         = '0;
    operand_valid_i   = '0;
    result_gnt_i      = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // State right after reset
    @(negedge clk_i);
    check_value("result_req_o", 64'(result_req_o), 64'd0);
    check_value("vinsn_done_o", 64'(vinsn_done_o), 64'd0);
    check_value("operand_ready_o", 64'(operand_ready_o), 64'd0);
    check_value("insn_ready_o", 64'(insn_ready_o), 64'd1);
    while (done_cnt < num_insn) begin
      @(posedge clk_i);
      #1;
      drive_insn();
      drive_operands();
      drive_gnt();
    end
    if (exp_q.size() == 0 && insn_q.size() == 0 && ready_dropped) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("Run ended with words still expected or insn_ready_o never dropped");
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      abort_run("Timeout: not all instructions completed within the cycle limit");
    end
  end

  ////////////////////
  // Compare
  ////////////////////

  // Mid-cycle, so every handshake of the coming edge is settled
  always @(negedge clk_i) begin
    insn_t cur;
    word_t exp;
    logic [63:0] opa;
    logic        accept;
    int          epw;
    int          left;
    int          bytes;
    if (rst_ni) begin
      check_value("insn_ready_o", 64'(insn_ready_o), 64'(inflight != 4));
      if (!insn_ready_o) ready_dropped = 1'b1;
      check_value("vinsn_done_o", 64'(vinsn_done_o), 64'(done_exp));
      if (done_exp != '0) done_cnt++;
      check_value("operand_ready_o without valid", 64'(operand_ready_o & ~operand_valid_i),
                  64'd0);
      opnd_taken = operand_ready_o;
      // One word issued at this edge
      if (operand_ready_o[1] && insn_q.size() == 0) begin
        abort_run("Operands accepted with no instruction waiting to issue");
      end else if (operand_ready_o[1]) begin
        cur = insn_q[0];
        check_value("operand_ready_o[0]", 64'(operand_ready_o[0]), 64'(!cur.use_scalar));
        opa      = cur.use_scalar ? replicate(cur.scalar, cur.vew) : operand_i[0];
        epw      = 8 >> cur.vew;
        left     = int'(cur.vl) - elem_pos;
        bytes    = ((left < epw) ? left : epw) << cur.vew;
        exp.id   = cur.id;
        exp.addr = 8'(int'(cur.vd) * `VALU_VREG_WORDS + elem_pos / epw);
        exp.data = ref_alu(cur.op, cur.vew, opa, operand_i[1]);
        exp.be   = (bytes >= 8) ? 8'hff : 8'((1 << bytes) - 1);
        exp.last = (left <= epw);
        exp_q.push_back(exp);
        if (exp.last) begin
          void'(insn_q.pop_front());
          elem_pos = 0;
        end else begin
          elem_pos = elem_pos + epw;
        end
      end else begin
        check_value("operand_ready_o[0]", 64'(operand_ready_o[0]), 64'd0);
      end
      // New instruction lands behind the one issuing
      accept     = insn_valid_i && insn_ready_o;
      insn_taken = accept;
      if (accept) begin
        cur.op         = insn_op_i;
        cur.vew        = insn_vew_i;
        cur.vl         = insn_vl_i;
        cur.vd         = insn_vd_i;
        cur.id         = insn_id_i;
        cur.use_scalar = insn_use_scalar_i;
        cur.scalar     = insn_scalar_i;
        insn_q.push_back(cur);
      end
      done_exp = '0;
      if (result_req_o && result_gnt_i && exp_q.size() == 0) begin
        abort_run("Register file write granted with no word expected");
      end else if (result_req_o && result_gnt_i) begin
        exp = exp_q.pop_front();
        check_value("result_id_o", 64'(result_id_o), 64'(exp.id));
        check_value("result_addr_o", 64'(result_addr_o), 64'(exp.addr));
        check_value("result_be_o", 64'(result_be_o), 64'(exp.be));
        check_value("result_wdata_o", result_wdata_o & byte_mask(exp.be),
                    exp.data & byte_mask(exp.be));
        // Done follows one cycle after the last grant
        if (exp.last) done_exp = `VALU_NR_VINSN'(1) << exp.id;
      end
      inflight = inflight + int'(accept) - int'(vinsn_done_o != '0);
    end
  end

endmodule

//--- vlog.f
+incdir+design
design/valu_pkg.sv
design/valu_simd_alu.sv
design/valu_issue.sv
design/valu_result_queue.sv
design/valu_commit.sv
design/valu.sv
sim/tb_valu.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_valu -f vlog.f -o tb_valu \
  && ./obj_dir/tb_valu \
  || exit 1
